// ==== src/vlsu_pkg.sv ====
////////////////////
// Vector LSU package
// Widths, opcodes and the helpers shared by both sides of the unit
////////////////////

package vlsu_pkg;

  localparam int ADDR_W         = 32;
  localparam int ELEN           = 32;
  localparam int ELENB          = 4;
  localparam int VELE           = 8;
  localparam int NR_VREG        = 32;
  localparam int VREG_W         = $clog2(NR_VREG);
  localparam int VRF_ADDR_W     = 8;
  localparam int VL_W           = 6;
  localparam int NR_OUTSTANDING = 4;
  localparam int ID_W           = 2;
  localparam int INSTR_ID_W     = 3;

  typedef enum logic [1:0] {OP_VLE, OP_VSE, OP_VLSE, OP_VSSE} lsu_op_e;

  typedef enum logic [1:0] {EW_8, EW_16, EW_32} vsew_e;

  // Element size in bytes
  function automatic logic [2:0] elem_bytes(vsew_e ew);
    return 3'd1 << ew;
  endfunction

  // Byte mask of a single element at byte 0
  function automatic logic [ELENB-1:0] elem_mask(vsew_e ew);
    unique case (ew)
      EW_8:    return 4'b0001;
      EW_16:   return 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  // Mask of the lowest n bytes of a word
  function automatic logic [ELENB-1:0] first_bytes(logic [VL_W-1:0] n);
    logic [ELENB-1:0] mask;
    for (int k = 0; k < ELENB; k++) begin
      mask[k] = k < n;
    end
    return mask;
  endfunction

  // Bytes retired per transfer: one element when strided, else up to a word
  function automatic logic [VL_W-1:0] step_bytes(logic strided, vsew_e ew,
                                                 logic [VL_W-1:0] remaining);
    if (strided) return VL_W'(elem_bytes(ew));
    if (remaining < VL_W'(ELENB)) return remaining;
    return VL_W'(ELENB);
  endfunction

  // Byte address of the element at packed byte position cnt
  function automatic logic [ADDR_W-1:0] elem_addr(logic [ADDR_W-1:0] rs1,
                                                  logic [ADDR_W-1:0] rs2,
                                                  logic [VL_W-1:0] cnt, vsew_e ew);
    logic [VL_W-1:0] idx;
    idx = cnt >> ew;
    return rs1 + ADDR_W'(idx) * rs2;
  endfunction

  // Rotate a word left by whole bytes
  function automatic logic [ELEN-1:0] rotl_bytes(logic [ELEN-1:0] data, logic [1:0] sh);
    logic [2*ELEN-1:0] dbl;
    dbl = {data, data} << (8 * sh);
    return dbl[2*ELEN-1:ELEN];
  endfunction

endpackage

// ==== src/vlsu_intf.sv ====
////////////////////
// Vector LSU interfaces
// Latched instruction and reorder-buffer ports
////////////////////

`timescale 1ns/1ps

interface vlsu_instr_if
  import vlsu_pkg::*;
();

  logic                  active;
  logic                  is_load;
  logic                  is_strided;
  vsew_e                 vsew;
  logic [ADDR_W-1:0]     rs1;
  logic [ADDR_W-1:0]     rs2;
  logic [VREG_W-1:0]     vd;
  logic [VL_W-1:0]       vl_bytes;
  // Side has retired all its bytes, or is idle
  logic                  mem_done;
  logic                  vrf_done;

  modport ctrl (output active, is_load, is_strided, vsew, rs1, rs2, vd, vl_bytes,
                input mem_done, vrf_done);
  modport mem  (input active, is_load, is_strided, vsew, rs1, rs2, vl_bytes, vrf_done,
                output mem_done);
  modport vrf  (input active, is_load, is_strided, vsew, rs1, rs2, vd, vl_bytes, mem_done,
                output vrf_done);

endinterface

interface vlsu_rob_if
  import vlsu_pkg::*;
();

  logic            push, pop, req_id;
  logic [ELEN-1:0] wdata;
  logic [ID_W-1:0] wid;
  logic [ELEN-1:0] rdata;
  logic            rvalid;
  logic [ID_W-1:0] rid;
  logic [ID_W-1:0] id;
  logic            full;
  logic            empty;

  // Per-side requests, each side drives zeros outside its role
  logic            mem_push, mem_pop, mem_req_id;
  logic [ELEN-1:0] mem_wdata;
  logic [ID_W-1:0] mem_wid;
  logic            vrf_push, vrf_pop, vrf_req_id;
  logic [ELEN-1:0] vrf_wdata;
  logic [ID_W-1:0] vrf_wid;

  assign push   = mem_push | vrf_push;
  assign pop    = mem_pop | vrf_pop;
  assign req_id = mem_req_id | vrf_req_id;
  assign wdata  = mem_wdata | vrf_wdata;
  assign wid    = mem_wid | vrf_wid;

  modport buffer (input push, pop, req_id, wdata, wid,
                  output rdata, rvalid, rid, id, full, empty);
  modport mem    (output mem_push, mem_pop, mem_req_id, mem_wdata, mem_wid,
                  input rdata, rvalid, rid, id, full);
  modport vrf    (output vrf_push, vrf_pop, vrf_req_id, vrf_wdata, vrf_wid,
                  input rdata, rvalid, id, full);

endinterface

// ==== src/vlsu_ctrl.sv ====
////////////////////
// Vector LSU controller
// Latches one instruction and signals its completion
////////////////////

`timescale 1ns/1ps

module vlsu_ctrl
  import vlsu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  lsu_op_e               req_op_i,
  input  vsew_e                 req_vsew_i,
  input  logic [VL_W-1:0]       req_vl_i,
  input  logic [ADDR_W-1:0]     req_rs1_i,
  input  logic [ADDR_W-1:0]     req_rs2_i,
  input  logic [VREG_W-1:0]     req_vd_i,
  input  logic [INSTR_ID_W-1:0] req_id_i,
  output logic                  rsp_valid_o,
  output logic [INSTR_ID_W-1:0] rsp_id_o,
  output logic [VREG_W-1:0]     rsp_vd_o,
  output logic                  mem_finished_o,
  vlsu_instr_if.ctrl            instr
);

  logic                  active_q;
  lsu_op_e               op_q;
  logic [INSTR_ID_W-1:0] id_q;
  logic                  finish;
  logic                  accept;

  // Both sides retired everything
  assign finish      = instr.mem_done & instr.vrf_done;
  assign req_ready_o = ~active_q | finish;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q <= 1'b0;
    end else if (accept) begin
      active_q <= 1'b1;
    end else if (finish) begin
      active_q <= 1'b0;
    end
  end

  // Request register, vl is kept in bytes
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q       <= req_op_i;
      id_q       <= req_id_i;
      instr.vsew <= req_vsew_i;
      instr.rs1  <= req_rs1_i;
      instr.rs2  <= req_rs2_i;
      instr.vd   <= req_vd_i;
      unique case (req_vsew_i)
        EW_8:    instr.vl_bytes <= req_vl_i;
        EW_16:   instr.vl_bytes <= req_vl_i << 1;
        EW_32:   instr.vl_bytes <= req_vl_i << 2;
        default: instr.vl_bytes <= '0;
      endcase
    end
  end

  assign instr.active     = active_q;
  assign instr.is_load    = (op_q == OP_VLE) || (op_q == OP_VLSE);
  assign instr.is_strided = (op_q == OP_VLSE) || (op_q == OP_VSSE);

  // Response frees the scoreboard entry
  assign rsp_valid_o    = active_q & finish;
  assign rsp_id_o       = id_q;
  assign rsp_vd_o       = instr.vd;
  assign mem_finished_o = rsp_valid_o;

endmodule

// ==== src/vlsu_rob.sv ====
////////////////////
// Vector LSU reorder buffer
// Id-tagged entries between memory side and register side
////////////////////

`timescale 1ns/1ps

module vlsu_rob
  import vlsu_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  vlsu_rob_if.buffer  rob
);

  logic [ELEN-1:0]           data_q [NR_OUTSTANDING];
  logic [NR_OUTSTANDING-1:0] valid_q;
  logic [ID_W-1:0]           wptr_q;
  logic [ID_W-1:0]           rptr_q;
  // Ids handed out and not yet popped
  logic [ID_W:0]             count_q;

  /////////////////////
  // Pointers and flags
  /////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (rob.req_id) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (rob.pop) begin
        rptr_q          <= rptr_q + 1'b1;
        valid_q[rptr_q] <= 1'b0;
      end
      // A push always targets an entry other than the head being popped
      if (rob.push) begin
        valid_q[rob.wid] <= 1'b1;
      end
      unique case ({rob.req_id, rob.pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  /////////////////////
  // Entry storage
  /////////////////////

  always_ff @(posedge clk_i) begin
    if (rob.push) begin
      data_q[rob.wid] <= rob.wdata;
    end
  end

  assign rob.full  = count_q == (ID_W + 1)'(NR_OUTSTANDING);
  assign rob.empty = count_q == '0;
  assign rob.id    = wptr_q;
  assign rob.rid   = rptr_q;

  // Head is presented in id order once its data has arrived
  assign rob.rdata  = data_q[rptr_q];
  assign rob.rvalid = valid_q[rptr_q] & ~rob.empty;

endmodule

// ==== src/vlsu_mem_side.sv ====
////////////////////
// Vector LSU memory side
// Address, strobe and store data generation per memory request
////////////////////

`timescale 1ns/1ps

module vlsu_mem_side
  import vlsu_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  vlsu_instr_if.mem         instr,
  vlsu_rob_if.mem           rob,
  output logic              mem_valid_o,
  input  logic              mem_ready_i,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic              mem_we_o,
  output logic [ELENB-1:0]  mem_strb_o,
  output logic [ELEN-1:0]   mem_wdata_o,
  output logic [ID_W-1:0]   mem_id_o,
  output logic              mem_last_o,
  input  logic              result_valid_i,
  input  logic [ID_W-1:0]   result_id_i,
  input  logic [ELEN-1:0]   result_rdata_i
);

  logic [VL_W-1:0]   cnt_q;
  logic [VL_W-1:0]   remaining;
  logic [VL_W-1:0]   delta;
  logic              busy;
  logic              accept;
  logic [ADDR_W-1:0] byte_addr;
  logic [1:0]        offset;

  assign remaining = instr.vl_bytes - cnt_q;
  assign busy      = instr.active & (cnt_q != instr.vl_bytes);
  assign delta     = step_bytes(instr.is_strided, instr.vsew, remaining);
  assign instr.mem_done = ~busy;

  // Byte counter, cleared once both sides are done
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (~busy & instr.vrf_done) begin
      cnt_q <= '0;
    end else if (accept) begin
      cnt_q <= cnt_q + delta;
    end
  end

  /////////////////////
  // Address and strobe
  /////////////////////

  assign byte_addr = instr.is_strided ?
                     elem_addr(instr.rs1, instr.rs2, cnt_q, instr.vsew) :
                     instr.rs1 + ADDR_W'(cnt_q);
  assign offset     = byte_addr[1:0];
  assign mem_addr_o = {byte_addr[ADDR_W-1:2], 2'b00};
  assign mem_strb_o = instr.is_strided ? elem_mask(instr.vsew) << offset :
                      first_bytes(delta);

  // Element moves from its packed register byte to the memory byte
  assign mem_wdata_o = rotl_bytes(rob.rdata, offset - cnt_q[1:0]);

  /////////////////////
  // Request handshake
  /////////////////////

  assign mem_valid_o = busy & (instr.is_load ? ~rob.full : rob.rvalid);
  assign mem_we_o    = ~instr.is_load;
  assign mem_id_o    = instr.is_load ? rob.id : rob.rid;
  assign mem_last_o  = remaining <= delta;
  assign accept      = mem_valid_o & mem_ready_i;

  // Loads take a new id per request, stores drain the head
  assign rob.mem_req_id = accept & instr.is_load;
  assign rob.mem_pop    = accept & ~instr.is_load;

  // Load results land in the entry named by their id
  assign rob.mem_push  = instr.active & instr.is_load & result_valid_i;
  assign rob.mem_wdata = rob.mem_push ? result_rdata_i : '0;
  assign rob.mem_wid   = rob.mem_push ? result_id_i : '0;

endmodule

// ==== src/vlsu_vrf_side.sv ====
////////////////////
// Vector LSU register side
// VRF addressing, write enables and load data alignment
////////////////////

`timescale 1ns/1ps

module vlsu_vrf_side
  import vlsu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  vlsu_instr_if.vrf             instr,
  vlsu_rob_if.vrf               rob,
  output logic [VRF_ADDR_W-1:0] vrf_waddr_o,
  output logic [ELEN-1:0]       vrf_wdata_o,
  output logic                  vrf_we_o,
  output logic [ELENB-1:0]      vrf_wbe_o,
  input  logic                  vrf_wvalid_i,
  output logic [VRF_ADDR_W-1:0] vrf_raddr_o,
  output logic                  vrf_re_o,
  input  logic [ELEN-1:0]       vrf_rdata_i,
  input  logic                  vrf_rvalid_i
);

  logic [VL_W-1:0]       cnt_q;
  logic [VL_W-1:0]       remaining;
  logic [VL_W-1:0]       delta;
  logic                  busy;
  logic                  wr_done;
  logic                  rd_done;
  logic [VRF_ADDR_W-1:0] vreg_addr;
  logic [ADDR_W-1:0]     src_addr;
  logic [1:0]            mem_off;

  assign remaining = instr.vl_bytes - cnt_q;
  assign busy      = instr.active & (cnt_q != instr.vl_bytes);
  assign delta     = step_bytes(instr.is_strided, instr.vsew, remaining);
  assign instr.vrf_done = ~busy;

  // Packed register byte counter
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (~busy & instr.mem_done) begin
      cnt_q <= '0;
    end else if (wr_done | rd_done) begin
      cnt_q <= cnt_q + delta;
    end
  end

  // Word within register vd holding the current byte
  assign vreg_addr = VRF_ADDR_W'(instr.vd) * VRF_ADDR_W'(VELE) +
                     VRF_ADDR_W'(cnt_q >> $clog2(ELENB));
  assign vrf_waddr_o = vreg_addr;
  assign vrf_raddr_o = vreg_addr;

  /////////////////////
  // Load write-back
  /////////////////////

  // Memory byte offset of the element now at the head
  assign src_addr = elem_addr(instr.rs1, instr.rs2, cnt_q, instr.vsew);
  assign mem_off  = src_addr[1:0];

  assign vrf_we_o    = busy & instr.is_load & rob.rvalid;
  assign vrf_wdata_o = instr.is_strided ? rotl_bytes(rob.rdata, cnt_q[1:0] - mem_off) :
                       rob.rdata;
  assign vrf_wbe_o   = instr.is_strided ? elem_mask(instr.vsew) << cnt_q[1:0] :
                       first_bytes(delta);
  assign wr_done     = vrf_we_o & vrf_wvalid_i;
  assign rob.vrf_pop = wr_done;

  /////////////////////
  // Store read
  /////////////////////

  // Reads only start while the buffer has room
  assign vrf_re_o = busy & ~instr.is_load & ~rob.full;
  assign rd_done  = vrf_re_o & vrf_rvalid_i;

  assign rob.vrf_push   = rd_done;
  assign rob.vrf_req_id = rd_done;
  assign rob.vrf_wdata  = rd_done ? vrf_rdata_i : '0;
  assign rob.vrf_wid    = rd_done ? rob.id : '0;

endmodule

// ==== src/vlsu_top.sv ====
////////////////////
// Vector load/store unit
// Controller, memory side, register side and reorder buffer
////////////////////

`timescale 1ns/1ps

module vlsu_top
  import vlsu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Instruction request and response
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  lsu_op_e               req_op_i,
  input  vsew_e                 req_vsew_i,
  input  logic [VL_W-1:0]       req_vl_i,
  input  logic [ADDR_W-1:0]     req_rs1_i,
  input  logic [ADDR_W-1:0]     req_rs2_i,
  input  logic [VREG_W-1:0]     req_vd_i,
  input  logic [INSTR_ID_W-1:0] req_id_i,
  output logic                  rsp_valid_o,
  output logic [INSTR_ID_W-1:0] rsp_id_o,
  output logic [VREG_W-1:0]     rsp_vd_o,
  output logic                  mem_finished_o,
  // Memory port
  output logic                  mem_valid_o,
  input  logic                  mem_ready_i,
  output logic [ADDR_W-1:0]     mem_addr_o,
  output logic                  mem_we_o,
  output logic [ELENB-1:0]      mem_strb_o,
  output logic [ELEN-1:0]       mem_wdata_o,
  output logic [ID_W-1:0]       mem_id_o,
  output logic                  mem_last_o,
  input  logic                  result_valid_i,
  input  logic [ID_W-1:0]       result_id_i,
  input  logic [ELEN-1:0]       result_rdata_i,
  // VRF port
  output logic [VRF_ADDR_W-1:0] vrf_waddr_o,
  output logic [ELEN-1:0]       vrf_wdata_o,
  output logic                  vrf_we_o,
  output logic [ELENB-1:0]      vrf_wbe_o,
  input  logic                  vrf_wvalid_i,
  output logic [VRF_ADDR_W-1:0] vrf_raddr_o,
  output logic                  vrf_re_o,
  input  logic [ELEN-1:0]       vrf_rdata_i,
  input  logic                  vrf_rvalid_i
);

  vlsu_instr_if instr_if ();
  vlsu_rob_if   rob_if ();

  vlsu_ctrl i_vlsu_ctrl (
    .clk_i, .arst_n_i, .req_valid_i, .req_ready_o, .req_op_i, .req_vsew_i,
    .req_vl_i, .req_rs1_i, .req_rs2_i, .req_vd_i, .req_id_i,
    .rsp_valid_o, .rsp_id_o, .rsp_vd_o, .mem_finished_o,
    .instr (instr_if.ctrl)
  );

  vlsu_rob i_vlsu_rob (
    .clk_i, .arst_n_i,
    .rob   (rob_if.buffer)
  );

  vlsu_mem_side i_vlsu_mem_side (
    .clk_i, .arst_n_i,
    .instr (instr_if.mem),
    .rob   (rob_if.mem),
    .mem_valid_o, .mem_ready_i, .mem_addr_o, .mem_we_o, .mem_strb_o,
    .mem_wdata_o, .mem_id_o, .mem_last_o,
    .result_valid_i, .result_id_i, .result_rdata_i
  );

  vlsu_vrf_side i_vlsu_vrf_side (
    .clk_i, .arst_n_i,
    .instr (instr_if.vrf),
    .rob   (rob_if.vrf),
    .vrf_waddr_o, .vrf_wdata_o, .vrf_we_o, .vrf_wbe_o, .vrf_wvalid_i,
    .vrf_raddr_o, .vrf_re_o, .vrf_rdata_i, .vrf_rvalid_i
  );

endmodule

// ==== sim/vlsu_props.sv ====
////////////////////
// Vector LSU protocol checks
// Bound to the top level
////////////////////

`timescale 1ns/1ps

module vlsu_props
  import vlsu_pkg::*;
(
  input logic                  clk_i,
  input logic                  arst_n_i,
  input logic                  req_valid_i,
  input logic                  req_ready_o,
  input logic                  rsp_valid_o,
  input logic                  mem_valid_o,
  input logic                  mem_ready_i,
  input logic [ADDR_W-1:0]     mem_addr_o,
  input logic                  mem_we_o,
  input logic [ELENB-1:0]      mem_strb_o,
  input logic [ELEN-1:0]       mem_wdata_o
);

  // Pending memory request keeps address, strobe and store data
  a_mem_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o) &&
      $stable(mem_strb_o) && (!mem_we_o || $stable(mem_wdata_o)))
    else $error("Memory request changed before it was accepted");

  // An accepted instruction keeps the unit busy, so the next one waits
  a_no_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i && req_ready_o |=> !req_ready_o)
    else $error("Unit ready again right after accepting an instruction");

  // Single-cycle response
  a_rsp_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_o |=> !rsp_valid_o)
    else $error("Response lasted longer than one cycle");

endmodule

bind vlsu_top vlsu_props i_vlsu_props (
  .clk_i, .arst_n_i, .req_valid_i, .req_ready_o, .rsp_valid_o,
  .mem_valid_o, .mem_ready_i, .mem_addr_o, .mem_we_o, .mem_strb_o, .mem_wdata_o
);

// ==== sim/tb_vlsu.sv ====
////////////////////
// Vector LSU testbench
// Instruction table run against memory and VRF models
////////////////////

`timescale 1ns/1ps

module tb_vlsu
  import vlsu_pkg::*;
();

  localparam int NR_ROWS   = 9;
  localparam int MEM_WORDS = 256;
  localparam int TIMEOUT   = 1000;

  typedef struct packed {
    lsu_op_e               op;
    vsew_e                 ew;
    logic [VL_W-1:0]       vl;
    logic [ADDR_W-1:0]     rs1;
    logic [ADDR_W-1:0]     rs2;
    logic [VREG_W-1:0]     vd;
    logic [INSTR_ID_W-1:0] id;
  } row_t;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  req_valid_i;
  logic                  req_ready_o;
  lsu_op_e               req_op_i;
  vsew_e                 req_vsew_i;
  logic [VL_W-1:0]       req_vl_i;
  logic [ADDR_W-1:0]     req_rs1_i;
  logic [ADDR_W-1:0]     req_rs2_i;
  logic [VREG_W-1:0]     req_vd_i;
  logic [INSTR_ID_W-1:0] req_id_i;
  logic                  rsp_valid_o;
  logic [INSTR_ID_W-1:0] rsp_id_o;
  logic [VREG_W-1:0]     rsp_vd_o;
  logic                  mem_finished_o;
  logic                  mem_valid_o;
  logic                  mem_ready_i    = 1'b0;
  logic [ADDR_W-1:0]     mem_addr_o;
  logic                  mem_we_o;
  logic [ELENB-1:0]      mem_strb_o;
  logic [ELEN-1:0]       mem_wdata_o;
  logic [ID_W-1:0]       mem_id_o;
  logic                  mem_last_o;
  logic                  result_valid_i = 1'b0;
  logic [ID_W-1:0]       result_id_i    = '0;
  logic [ELEN-1:0]       result_rdata_i = '0;
  logic [VRF_ADDR_W-1:0] vrf_waddr_o;
  logic [ELEN-1:0]       vrf_wdata_o;
  logic                  vrf_we_o;
  logic [ELENB-1:0]      vrf_wbe_o;
  logic                  vrf_wvalid_i   = 1'b0;
  logic [VRF_ADDR_W-1:0] vrf_raddr_o;
  logic                  vrf_re_o;
  logic [ELEN-1:0]       vrf_rdata_i    = '0;
  logic                  vrf_rvalid_i   = 1'b0;

  logic [ELEN-1:0]      mem     [MEM_WORDS];
  logic [ELEN-1:0]      exp_mem [MEM_WORDS];
  logic [ELEN-1:0]      vrf     [NR_VREG*VELE];
  logic [ELEN-1:0]      exp_vrf [NR_VREG*VELE];
  row_t                 rows    [NR_ROWS];
  logic [ID_W+ELEN-1:0] pend_q  [$];
  logic [ID_W+ELEN-1:0] item;
  logic [31:0]          draw;
  int                   pick;
  integer               seed      = 32'h141f;
  int                   rsp_count = 0;
  // Memory requests seen and expected for the instruction in flight
  int                   req_seen  = 0;
  int                   req_total = 0;

  vlsu_top i_vlsu_top (
    .clk_i, .arst_n_i, .req_valid_i, .req_ready_o, .req_op_i, .req_vsew_i,
    .req_vl_i, .req_rs1_i, .req_rs2_i, .req_vd_i, .req_id_i,
    .rsp_valid_o, .rsp_id_o, .rsp_vd_o, .mem_finished_o,
    .mem_valid_o, .mem_ready_i, .mem_addr_o, .mem_we_o, .mem_strb_o,
    .mem_wdata_o, .mem_id_o, .mem_last_o,
    .result_valid_i, .result_id_i, .result_rdata_i,
    .vrf_waddr_o, .vrf_wdata_o, .vrf_we_o, .vrf_wbe_o, .vrf_wvalid_i,
    .vrf_raddr_o, .vrf_re_o, .vrf_rdata_i, .vrf_rvalid_i
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic report_fail(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  // Opcode, width, vl, rs1, rs2, vd, id
  task automatic fill_table();
    rows[0] = '{OP_VLE,  EW_32, 6'd8,  32'h100, 32'h0,        5'd2, 3'd1};
    rows[1] = '{OP_VSE,  EW_8,  6'd7,  32'h200, 32'h0,        5'd3, 3'd2};
    rows[2] = '{OP_VLSE, EW_16, 6'd6,  32'h302, 32'd6,        5'd4, 3'd3};
    rows[3] = '{OP_VSSE, EW_8,  6'd9,  32'h381, 32'd5,        5'd5, 3'd4};
    rows[4] = '{OP_VLE,  EW_8,  6'd13, 32'h140, 32'h0,        5'd6, 3'd5};
    rows[5] = '{OP_VSE,  EW_32, 6'd5,  32'h240, 32'h0,        5'd2, 3'd6};
    rows[6] = '{OP_VLSE, EW_32, 6'd4,  32'h104, 32'd12,       5'd7, 3'd7};
    rows[7] = '{OP_VSSE, EW_16, 6'd5,  32'h3c0, 32'hfffffffa, 5'd4, 3'd0};
    rows[8] = '{OP_VLE,  EW_16, 6'd16, 32'h200, 32'h0,        5'd9, 3'd3};
  endtask

  // One request per element when strided, else one per started word
  function automatic int count_requests(input row_t r);
    int nbytes;
    nbytes = int'(r.vl) << r.ew;
    if (r.op == OP_VLSE || r.op == OP_VSSE) begin
      return int'(r.vl);
    end
    return (nbytes + ELENB - 1) / ELENB;
  endfunction

  // Reference move of every packed register byte
  task automatic apply_expected(input row_t r);
    int          esz;
    int          nbytes;
    logic [31:0] ma;
    logic [31:0] va;
    esz    = 1 << r.ew;
    nbytes = int'(r.vl) * esz;
    for (int b = 0; b < nbytes; b++) begin
      if (r.op == OP_VLSE || r.op == OP_VSSE) begin
        ma = r.rs1 + (b / esz) * r.rs2 + b % esz;
      end else begin
        ma = r.rs1 + b;
      end
      va = r.vd * 32 + b;
      if (r.op == OP_VLE || r.op == OP_VLSE) begin
        exp_vrf[va[9:2]][8*va[1:0] +: 8] = exp_mem[ma[9:2]][8*ma[1:0] +: 8];
      end else begin
        exp_mem[ma[9:2]][8*ma[1:0] +: 8] = exp_vrf[va[9:2]][8*va[1:0] +: 8];
      end
    end
  endtask

  task automatic compare_models(input int n);
    for (int i = 0; i < MEM_WORDS; i++) begin
      assert (mem[i] === exp_mem[i]) else
        report_fail($sformatf("ERR %0t: row %0d memory word 0x%0h is %08h, expected %08h",
                              $time, n, 4 * i, mem[i], exp_mem[i]));
      assert (vrf[i] === exp_vrf[i]) else
        report_fail($sformatf("ERR %0t: row %0d VRF word %0d is %08h, expected %08h",
                              $time, n, i, vrf[i], exp_vrf[i]));
    end
  endtask

  task automatic run_row(input int n);
    row_t r;
    int   cycles;
    bit   done;
    r = rows[n];
    apply_expected(r);
    req_total = count_requests(r);
    req_valid_i <= 1'b1;
    req_op_i    <= r.op;
    req_vsew_i  <= r.ew;
    req_vl_i    <= r.vl;
    req_rs1_i   <= r.rs1;
    req_rs2_i   <= r.rs2;
    req_vd_i    <= r.vd;
    req_id_i    <= r.id;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      cycles++;
      if (req_ready_o) begin
        done = 1'b1;
      end else if (cycles > TIMEOUT) begin
        report_fail($sformatf("Timeout waiting for row %0d to be accepted", n));
      end
    end
    req_valid_i <= 1'b0;
    // Busy until the single response
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      cycles++;
      if (rsp_valid_o) begin
        done = 1'b1;
      end else begin
        assert (!req_ready_o) else
          report_fail($sformatf("ERR %0t: req_ready_o high while row %0d in flight", $time, n));
        if (cycles > TIMEOUT) begin
          report_fail($sformatf("Timeout waiting for the response of row %0d", n));
        end
      end
    end
    assert (rsp_id_o == r.id && rsp_vd_o == r.vd && mem_finished_o) else
      report_fail($sformatf("ERR %0t: row %0d response id %0d vd %0d finished %0b", $time, n,
                            rsp_id_o, rsp_vd_o, mem_finished_o));
    @(posedge clk_i);
    assert (rsp_count == n + 1) else
      report_fail($sformatf("ERR %0t: %0d responses after row %0d", $time, rsp_count, n));
    compare_models(n);
  endtask

  ////////////////////
  // Memory and VRF models
  ////////////////////

  always @(posedge clk_i) begin
    draw = $random(seed);
    // Return one pending result, sometimes the second oldest
    result_valid_i <= 1'b0;
    if (pend_q.size() > 0 && draw[0]) begin
      pick = (pend_q.size() > 1 && draw[1]) ? 1 : 0;
      item = pend_q[pick];
      pend_q.delete(pick);
      result_valid_i <= 1'b1;
      result_id_i    <= item[ID_W+ELEN-1:ELEN];
      result_rdata_i <= item[ELEN-1:0];
    end
    // All requests of the instruction precede its response
    if (rsp_valid_o) begin
      assert (req_seen == req_total) else
        report_fail($sformatf("ERR %0t: %0d memory requests, expected %0d", $time,
                              req_seen, req_total));
      req_seen = 0;
    end
    if (mem_valid_o && mem_ready_i) begin
      assert (mem_last_o == (req_seen == req_total - 1)) else
        report_fail($sformatf("ERR %0t: mem_last_o is %0b on request %0d of %0d", $time,
                              mem_last_o, req_seen + 1, req_total));
      req_seen++;
      if (mem_we_o) begin
        for (int k = 0; k < ELENB; k++) begin
          if (mem_strb_o[k]) begin
            mem[mem_addr_o[9:2]][8*k +: 8] = mem_wdata_o[8*k +: 8];
          end
        end
      end else begin
        pend_q.push_back({mem_id_o, mem[mem_addr_o[9:2]]});
      end
    end
    mem_ready_i  <= draw[2] | draw[3];
    vrf_wvalid_i <= draw[4];
    if (vrf_we_o && vrf_wvalid_i) begin
      for (int k = 0; k < ELENB; k++) begin
        if (vrf_wbe_o[k]) begin
          vrf[vrf_waddr_o][8*k +: 8] = vrf_wdata_o[8*k +: 8];
        end
      end
    end
    // Read data follows one cycle after the read request
    if (vrf_re_o && !vrf_rvalid_i) begin
      vrf_rvalid_i <= 1'b1;
      vrf_rdata_i  <= vrf[vrf_raddr_o];
    end else begin
      vrf_rvalid_i <= 1'b0;
    end
  end

  always @(posedge clk_i) begin
    if (rsp_valid_o) begin
      rsp_count <= rsp_count + 1;
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    logic [7:0] w;
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = OP_VLE;
    req_vsew_i  = EW_8;
    req_vl_i    = '0;
    req_rs1_i   = '0;
    req_rs2_i   = '0;
    req_vd_i    = '0;
    req_id_i    = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      w          = i[7:0];
      mem[i]     = {w ^ 8'hc3, w + 8'h41, ~w, w};
      exp_mem[i] = mem[i];
      vrf[i]     = {~w, w ^ 8'h5a, w + 8'h17, w ^ 8'he1};
      exp_vrf[i] = vrf[i];
    end
    fill_table();
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    assert (req_ready_o && !rsp_valid_o && !mem_finished_o && !mem_valid_o &&
            !vrf_we_o && !vrf_re_o) else
      report_fail($sformatf("ERR %0t: outputs not idle after reset", $time));
    for (int n = 0; n < NR_ROWS; n++) begin
      run_row(n);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== flist.f ====
src/vlsu_pkg.sv
src/vlsu_intf.sv
src/vlsu_ctrl.sv
src/vlsu_rob.sv
src/vlsu_mem_side.sv
src/vlsu_vrf_side.sv
src/vlsu_top.sv
sim/vlsu_props.sv
sim/tb_vlsu.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the vector LSU testbench with Verilator

verilator --binary --timing --assert -Wno-fatal --top-module tb_vlsu -f flist.f \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vtb_vlsu > sim.log 2>&1

grep -q "Result: PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
